// File: common/la32_pkg.sv
`default_nettype none

package la32_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;
    localparam logic [31:0]     NOP_INST = 32'h0000_0000;

    // opcode fields, compared against the instruction's top bits
    localparam logic [11:0] OP_3R     = 12'h001;
    localparam logic [4:0]  F3_ADD    = 5'h00;
    localparam logic [4:0]  F3_SUB    = 5'h02;
    localparam logic [4:0]  F3_SLT    = 5'h04;
    localparam logic [4:0]  F3_AND    = 5'h09;
    localparam logic [4:0]  F3_OR     = 5'h0a;
    localparam logic [4:0]  F3_XOR    = 5'h0b;
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;
    localparam logic [6:0]  OP_LU12I  = 7'h0a;
    localparam logic [5:0]  OP_B      = 6'h14;
    localparam logic [5:0]  OP_BEQ    = 6'h16;
    localparam logic [5:0]  OP_BNE    = 6'h17;

    // zero values double as the bubble encoding
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_B
    } br_kind_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs1_val;
        logic [XLEN-1:0]   rs2_val;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   br_offs;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        alu_op_e           alu_op;
        logic              src2_imm;
        br_kind_e          br_kind;
        logic              use_rs1;
        logic              use_rs2;
        logic              is_load;
        logic              is_store;
        logic              reg_write;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]   alu_res;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
        logic              is_load;
        logic              is_store;
        logic              reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]   alu_res;
        logic [XLEN-1:0]   load_data;
        logic [REG_AW-1:0] rd;
        logic              is_load;
        logic              reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: logic/la32_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module la32_regfile import la32_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic [REG_AW-1:0] raddr1,
    output logic [XLEN-1:0]        rdata1,
    input  wire logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]        rdata2,
    input  wire logic              we,
    input  wire logic [REG_AW-1:0] waddr,
    input  wire logic [XLEN-1:0]   wdata,
    input  wire logic [REG_AW-1:0] dbg_raddr,
    output logic [XLEN-1:0]        dbg_rdata
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero, a same-cycle write is passed straight through
    assign rdata1 = (raddr1 == '0) ? '0 : (we && raddr1 == waddr) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : (we && raddr2 == waddr) ? wdata : regs[raddr2];
    assign dbg_rdata = (dbg_raddr == '0) ? '0
                     : (we && dbg_raddr == waddr) ? wdata : regs[dbg_raddr];

endmodule

`default_nettype wire

// File: core/la32_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module la32_fetch import la32_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic            load_stall,
    input  wire logic            branch_taken,
    input  wire logic [XLEN-1:0] branch_target,
    output logic [XLEN-1:0]      inst_addr,
    input  wire logic [31:0]     inst_data,
    output logic [31:0]          if_inst,
    output logic [XLEN-1:0]      if_pc
);

    logic [XLEN-1:0] pc;

    assign inst_addr = pc;

    // redirect wins over the stall hold
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!load_stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (!rstn || branch_taken) begin
            if_inst <= NOP_INST;
            if_pc   <= '0;
        end else if (!load_stall) begin
            if_inst <= inst_data;
            if_pc   <= pc;
        end
    end

endmodule

`default_nettype wire

// File: core/la32_decode.sv
`timescale 1ns/1ps
`default_nettype none

module la32_decode import la32_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic [31:0]       if_inst,
    input  wire logic [XLEN-1:0]   if_pc,
    input  wire logic              load_stall,
    input  wire logic              branch_taken,
    output logic [REG_AW-1:0]      rf_raddr1,
    output logic [REG_AW-1:0]      rf_raddr2,
    input  wire logic [XLEN-1:0]   rf_rdata1,
    input  wire logic [XLEN-1:0]   rf_rdata2,
    output id_ex_t                 id_ex
);

    id_ex_t  dec;
    alu_op_e r3_op;
    logic    r3_ok;
    logic    is_3r;
    logic    is_addi;
    logic    is_ld;
    logic    is_st;
    logic    is_lu12i;
    logic    is_b;
    logic    is_beq;
    logic    is_bne;

    assign is_3r    = (if_inst[31:20] == OP_3R) && r3_ok;
    assign is_addi  = (if_inst[31:22] == OP_ADDI_W);
    assign is_ld    = (if_inst[31:22] == OP_LD_W);
    assign is_st    = (if_inst[31:22] == OP_ST_W);
    assign is_lu12i = (if_inst[31:25] == OP_LU12I);
    assign is_b     = (if_inst[31:26] == OP_B);
    assign is_beq   = (if_inst[31:26] == OP_BEQ);
    assign is_bne   = (if_inst[31:26] == OP_BNE);

    // stores and branches read rd on port 2
    assign rf_raddr1 = if_inst[9:5];
    assign rf_raddr2 = (is_st || is_beq || is_bne) ? if_inst[4:0] : if_inst[14:10];

    always_comb begin
        r3_ok = 1'b1;
        case (if_inst[19:15])
            F3_ADD: r3_op = ALU_ADD;
            F3_SUB: r3_op = ALU_SUB;
            F3_SLT: r3_op = ALU_SLT;
            F3_AND: r3_op = ALU_AND;
            F3_OR:  r3_op = ALU_OR;
            F3_XOR: r3_op = ALU_XOR;
            default: begin
                r3_op = ALU_ADD;
                r3_ok = 1'b0;
            end
        endcase
    end

    // anything not matched keeps all flags low
    always_comb begin
        dec         = '0;
        dec.pc      = if_pc;
        dec.rs1_val = rf_rdata1;
        dec.rs2_val = rf_rdata2;
        dec.rs1     = rf_raddr1;
        dec.rs2     = rf_raddr2;
        dec.rd      = if_inst[4:0];
        dec.imm     = is_lu12i ? {if_inst[24:5], 12'b0}
                               : {{20{if_inst[21]}}, if_inst[21:10]};
        dec.br_offs = is_b ? {{4{if_inst[9]}}, if_inst[9:0], if_inst[25:10], 2'b0}
                           : {{14{if_inst[25]}}, if_inst[25:10], 2'b0};
        if (is_3r) begin
            dec.alu_op    = r3_op;
            dec.use_rs1   = 1'b1;
            dec.use_rs2   = 1'b1;
            dec.reg_write = 1'b1;
        end else if (is_addi || is_ld) begin
            dec.use_rs1   = 1'b1;
            dec.src2_imm  = 1'b1;
            dec.is_load   = is_ld;
            dec.reg_write = 1'b1;
        end else if (is_st) begin
            dec.use_rs1  = 1'b1;
            dec.use_rs2  = 1'b1;
            dec.src2_imm = 1'b1;
            dec.is_store = 1'b1;
        end else if (is_lu12i) begin
            dec.alu_op    = ALU_LUI;
            dec.src2_imm  = 1'b1;
            dec.reg_write = 1'b1;
        end else if (is_beq || is_bne) begin
            dec.br_kind = is_beq ? BR_BEQ : BR_BNE;
            dec.use_rs1 = 1'b1;
            dec.use_rs2 = 1'b1;
        end else if (is_b) begin
            dec.br_kind = BR_B;
        end
    end

    // ID/EX
    always_ff @(posedge clk) begin
        if (!rstn || branch_taken) begin
            id_ex <= '0;
        end else if (!load_stall) begin
            id_ex <= dec;
        end
    end

endmodule

`default_nettype wire

// File: core/la32_execute.sv
`timescale 1ns/1ps
`default_nettype none

module la32_execute import la32_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire id_ex_t          id_ex,
    input  wire fwd_sel_e        fwd1_sel,
    input  wire fwd_sel_e        fwd2_sel,
    input  wire logic [XLEN-1:0] wb_data,
    input  wire logic            load_stall,
    output ex_mem_t              ex_mem,
    output logic                 branch_taken,
    output logic [XLEN-1:0]      branch_target
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] saved1;
    logic [XLEN-1:0] saved2;
    logic            replay;
    logic            take;

    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] rf_val,
        input logic [XLEN-1:0] exmem_val,
        input logic [XLEN-1:0] memwb_val
    );
        case (sel)
            FWD_EXMEM: return exmem_val;
            FWD_MEMWB: return memwb_val;
            default:   return rf_val;
        endcase
    endfunction

    // operands seen during a load-use stall, since the instruction ahead
    // of the load retires while ID/EX holds and can no longer be forwarded
    always_ff @(posedge clk) begin
        if (!rstn) begin
            replay <= 1'b0;
        end else begin
            replay <= load_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (load_stall) begin
            saved1 <= op1;
            saved2 <= op2;
        end
    end

    assign op1  = fwd_mux(fwd1_sel, replay ? saved1 : id_ex.rs1_val, ex_mem.alu_res, wb_data);
    assign op2  = fwd_mux(fwd2_sel, replay ? saved2 : id_ex.rs2_val, ex_mem.alu_res, wb_data);
    assign src2 = id_ex.src2_imm ? id_ex.imm : op2;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_res = op1 - src2;
            ALU_SLT: alu_res = {31'b0, $signed(op1) < $signed(src2)};
            ALU_AND: alu_res = op1 & src2;
            ALU_OR:  alu_res = op1 | src2;
            ALU_XOR: alu_res = op1 ^ src2;
            ALU_LUI: alu_res = src2;
            default: alu_res = op1 + src2;
        endcase
    end

    always_comb begin
        case (id_ex.br_kind)
            BR_BEQ:  take = (op1 == op2);
            BR_BNE:  take = (op1 != op2);
            BR_B:    take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    // compare is not valid yet while the load is still in EX/MEM
    assign branch_taken  = take && !load_stall;
    assign branch_target = id_ex.pc + id_ex.br_offs;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rstn || load_stall) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_res    <= alu_res;
            ex_mem.store_data <= op2;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.is_load    <= id_ex.is_load;
            ex_mem.is_store   <= id_ex.is_store;
            ex_mem.reg_write  <= id_ex.reg_write;
        end
    end

endmodule

`default_nettype wire

// File: core/la32_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module la32_mem_wb import la32_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire ex_mem_t         ex_mem,
    output logic [XLEN-1:0]      data_addr,
    output logic [XLEN-1:0]      data_wdata,
    output logic                 data_we,
    input  wire logic [XLEN-1:0] data_rdata,
    output mem_wb_t              mem_wb,
    output logic                 rf_we,
    output logic [REG_AW-1:0]    rf_waddr,
    output logic [XLEN-1:0]      wb_data
);

    // byte address, the memory decodes the word
    assign data_addr  = ex_mem.alu_res;
    assign data_wdata = ex_mem.store_data;
    assign data_we    = ex_mem.is_store;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_wb <= '0;
        end else begin
            mem_wb.alu_res   <= ex_mem.alu_res;
            mem_wb.load_data <= data_rdata;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.is_load   <= ex_mem.is_load;
            mem_wb.reg_write <= ex_mem.reg_write;
        end
    end

    assign rf_we    = mem_wb.reg_write;
    assign rf_waddr = mem_wb.rd;
    assign wb_data  = mem_wb.is_load ? mem_wb.load_data : mem_wb.alu_res;

endmodule

`default_nettype wire

// File: core/la32_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module la32_hazard import la32_pkg::*; (
    input  wire id_ex_t  id_ex,
    input  wire ex_mem_t ex_mem,
    input  wire mem_wb_t mem_wb,
    output fwd_sel_e     fwd1_sel,
    output fwd_sel_e     fwd2_sel,
    output logic         load_stall
);

    logic hit1_exmem;
    logic hit2_exmem;

    // younger result in EX/MEM takes precedence over MEM/WB
    function automatic fwd_sel_e pick(
        input logic              used,
        input logic [REG_AW-1:0] src,
        input logic              exmem_we,
        input logic [REG_AW-1:0] exmem_rd,
        input logic              memwb_we,
        input logic [REG_AW-1:0] memwb_rd
    );
        if (used && exmem_we && exmem_rd != '0 && exmem_rd == src) begin
            return FWD_EXMEM;
        end else if (used && memwb_we && memwb_rd != '0 && memwb_rd == src) begin
            return FWD_MEMWB;
        end else begin
            return FWD_RF;
        end
    endfunction

    assign fwd1_sel = pick(id_ex.use_rs1, id_ex.rs1, ex_mem.reg_write, ex_mem.rd,
                           mem_wb.reg_write, mem_wb.rd);
    assign fwd2_sel = pick(id_ex.use_rs2, id_ex.rs2, ex_mem.reg_write, ex_mem.rd,
                           mem_wb.reg_write, mem_wb.rd);

    // load one ahead of its consumer, caught with the consumer already in EX
    assign hit1_exmem = id_ex.use_rs1 && (id_ex.rs1 == ex_mem.rd);
    assign hit2_exmem = id_ex.use_rs2 && (id_ex.rs2 == ex_mem.rd);
    assign load_stall = ex_mem.is_load && (ex_mem.rd != '0) && (hit1_exmem || hit2_exmem);

endmodule

`default_nettype wire

// File: core/la32_core.sv
`timescale 1ns/1ps
`default_nettype none

module la32_core import la32_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rstn,
    output logic [XLEN-1:0]        inst_addr,
    input  wire logic [XLEN-1:0]   inst_data,
    output logic [XLEN-1:0]        data_addr,
    output logic [XLEN-1:0]        data_wdata,
    output logic                   data_we,
    input  wire logic [XLEN-1:0]   data_rdata,
    input  wire logic [REG_AW-1:0] dbg_raddr,
    output logic [XLEN-1:0]        dbg_rdata
);

    logic [31:0]       if_inst;
    logic [XLEN-1:0]   if_pc;
    logic              load_stall;
    logic              branch_taken;
    logic [XLEN-1:0]   branch_target;
    logic [REG_AW-1:0] rf_raddr1;
    logic [REG_AW-1:0] rf_raddr2;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   wb_data;
    fwd_sel_e          fwd1_sel;
    fwd_sel_e          fwd2_sel;
    id_ex_t            id_ex;
    ex_mem_t           ex_mem;
    mem_wb_t           mem_wb;

    la32_fetch fetch_i (
        .clk           (clk),
        .rstn          (rstn),
        .load_stall    (load_stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .inst_addr     (inst_addr),
        .inst_data     (inst_data),
        .if_inst       (if_inst),
        .if_pc         (if_pc)
    );

    la32_decode decode_i (
        .clk          (clk),
        .rstn         (rstn),
        .if_inst      (if_inst),
        .if_pc        (if_pc),
        .load_stall   (load_stall),
        .branch_taken (branch_taken),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .id_ex        (id_ex)
    );

    la32_execute execute_i (
        .clk           (clk),
        .rstn          (rstn),
        .id_ex         (id_ex),
        .fwd1_sel      (fwd1_sel),
        .fwd2_sel      (fwd2_sel),
        .wb_data       (wb_data),
        .load_stall    (load_stall),
        .ex_mem        (ex_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    la32_mem_wb mem_wb_i (
        .clk        (clk),
        .rstn       (rstn),
        .ex_mem     (ex_mem),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata),
        .mem_wb     (mem_wb),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .wb_data    (wb_data)
    );

    la32_hazard hazard_i (
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .fwd1_sel   (fwd1_sel),
        .fwd2_sel   (fwd2_sel),
        .load_stall (load_stall)
    );

    la32_regfile regfile_i (
        .clk       (clk),
        .rstn      (rstn),
        .raddr1    (rf_raddr1),
        .rdata1    (rf_rdata1),
        .raddr2    (rf_raddr2),
        .rdata2    (rf_rdata2),
        .we        (rf_we),
        .waddr     (rf_waddr),
        .wdata     (wb_data),
        .dbg_raddr (dbg_raddr),
        .dbg_rdata (dbg_rdata)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rstn
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // low over four rising edges, released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/tb_la32.sv
`timescale 1ns/1ps
`default_nettype none

module tb_la32;

    localparam logic [31:0] boot_pc = 32'h1c00_0000;

    logic        clk;
    logic        rstn;
    logic [31:0] inst_addr;
    logic [31:0] inst_data;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_we;
    logic [31:0] data_rdata;
    logic [4:0]  dbg_raddr;
    logic [31:0] dbg_rdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] exp_dmem [64];
    logic [31:0] exp_reg [32];
    logic [31:0] budget;
    int          limit = 1000;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    tb_clock clock_i (
        .clk  (clk),
        .rstn (rstn)
    );

    la32_core dut_i (
        .clk        (clk),
        .rstn       (rstn),
        .inst_addr  (inst_addr),
        .inst_data  (inst_data),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata),
        .dbg_raddr  (dbg_raddr),
        .dbg_rdata  (dbg_rdata)
    );

    // program sits in a 256-byte window at the boot address
    assign inst_data  = (inst_addr[31:8] == boot_pc[31:8]) ? imem[inst_addr[7:2]] : 32'h0;
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_we === 1'b1) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout, run still going after %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int              fd;
        int              n;
        int              i;
        logic [8*96-1:0] line;
        logic [7:0]      tag;
        logic [31:0]     a;
        logic [31:0]     v;
        ok     = 1'b0;
        budget = '0;
        // unused program slots hold words that decode as bubbles
        for (i = 0; i < 64; i++) begin
            imem[i]     = i * 4;
            dmem[i]    <= ~(i * 4);
            exp_dmem[i] = ~(i * 4);
        end
        for (i = 0; i < 32; i++) begin
            exp_reg[i] = 32'h0;
        end
        fd = $fopen("tb/la32_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                n    = $fgets(line, fd);
                tag  = 8'h0;
                if (n > 0 && $sscanf(line, "%s %h %h", tag, a, v) == 3) begin
                    case (tag)
                        "P": imem[a[5:0]] = v;
                        "M": begin
                            dmem[a[5:0]]    <= v;
                            exp_dmem[a[5:0]] = v;
                        end
                        "R": exp_reg[a[4:0]] = v;
                        "E": exp_dmem[a[5:0]] = v;
                        "C": budget = v;
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
            ok = (budget != 0);
        end
    endtask

    task automatic watch_reset();
        int first;
        int i;
        first = errors;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            compare_value("inst_addr", inst_addr, boot_pc);
            compare_value("data_we", {31'b0, data_we}, 32'h0);
        end
        // first cycle out of reset before the pc moves
        #5;
        compare_value("inst_addr", inst_addr, boot_pc);
        compare_value("data_we", {31'b0, data_we}, 32'h0);
        $display("reset test done, %0d errors", errors - first);
    endtask

    task automatic read_registers();
        int first;
        int i;
        first = errors;
        @(negedge clk);
        dbg_raddr = 5'd1;
        for (i = 1; i < 32; i++) begin
            @(negedge clk);
            compare_value($sformatf("dbg_rdata[r%0d]", i), dbg_rdata, exp_reg[i]);
            if (i < 31) begin
                dbg_raddr = 5'(i + 1);
            end
        end
        $display("register test done, %0d errors", errors - first);
    endtask

    task automatic scan_memory();
        int first;
        int i;
        first = errors;
        for (i = 0; i < 64; i++) begin
            compare_value($sformatf("dmem[0x%02h]", i * 4), dmem[i], exp_dmem[i]);
        end
        $display("memory test done, %0d errors", errors - first);
    endtask

    initial begin
        bit loaded;
        dbg_raddr = 5'd0;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("stimulus file is missing or gives no cycle budget");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            limit = budget + 50;
            watch_reset();
            repeat (budget) @(posedge clk);
            read_registers();
            scan_memory();
            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/la32_stimulus.txt
# tag index value, all hex: P program word, M initial data word
# R expected register, E expected data word, C cycle budget (index unused)
P 00 02810001 addi.w r1, r0, 0x40
P 01 02801c02 addi.w r2, r0, 7
P 02 02bff403 addi.w r3, r0, -3
P 03 142468a4 lu12i.w r4, 0x12345
P 04 00100c45 add.w r5, r2, r3
P 05 001108a6 sub.w r6, r5, r2
P 06 001208c7 slt r7, r6, r2
P 07 00148c88 and r8, r4, r3
P 08 00150889 or r9, r4, r2
P 09 0015912a xor r10, r9, r4
P 0a 2880002b ld.w r11, r1, 0
P 0b 0010096c add.w r12, r11, r2
P 0c 2980202c st.w r12, r1, 8
P 0d 2880102d ld.w r13, r1, 4
P 0e 2980302d st.w r13, r1, 12
P 0f 58000c4a beq r2, r10, +12
P 10 0280040e addi.w r14, r0, 1
P 11 0280040f addi.w r15, r0, 1
P 12 5c000ca5 bne r5, r5, +12
P 13 02804410 addi.w r16, r0, 0x11
P 14 50000c00 b +12
P 15 02800411 addi.w r17, r0, 1
P 16 02800412 addi.w r18, r0, 1
P 17 02bffc13 addi.w r19, r0, -1
P 18 29804033 st.w r19, r1, 16
P 19 50000000 b 0
M 10 12345678
M 11 00000005
R 01 00000040
R 02 00000007
R 03 fffffffd
R 04 12345000
R 05 00000004
R 06 fffffffd
R 07 00000001
R 08 12345000
R 09 12345007
R 0a 00000007
R 0b 12345678
R 0c 1234567f
R 0d 00000005
R 0e 00000000 shadow of beq
R 0f 00000000 shadow of beq
R 10 00000011
R 11 00000000 shadow of b
R 12 00000000 shadow of b
R 13 ffffffff
E 12 1234567f
E 13 00000005
E 14 ffffffff
C 00 0000003c

// File: verilog.f
common/la32_pkg.sv
logic/la32_regfile.sv
core/la32_fetch.sv
core/la32_decode.sv
core/la32_execute.sv
core/la32_mem_wb.sv
core/la32_hazard.sv
core/la32_core.sv
tb/tb_clock.sv
tb/tb_la32.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_la32 -f verilog.f > build.log 2>&1 \
    && ./obj_dir/Vtb_la32 > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
